//--- adc_sample.sv
`timescale 1ns/100ps
`default_nettype none

module adc_sample (
  input  logic            clk,
  input  logic            reset,
  input  logic            sample,
  input  scope_pkg::adc_t adc_x,
  input  scope_pkg::adc_t adc_y,
  output logic            plot,
  output scope_pkg::fb_x_t plot_x,
  output scope_pkg::fb_y_t plot_y
);
  import scope_pkg::*;

  // keep only the top bits of each reading
  localparam int X_SHIFT = $bits(adc_t) - $bits(fb_x_t);
  localparam int Y_SHIFT = $bits(adc_t) - $bits(fb_y_t);

  fb_x_t scaled_x;
  fb_y_t scaled_y;
  logic  on_screen;

  assign scaled_x = fb_x_t'(adc_x >> X_SHIFT);
  assign scaled_y = fb_y_t'(adc_y >> Y_SHIFT);

  // every column exists, only the lower rows do
  assign on_screen = (scaled_y < FB_HEIGHT);

  always_ff @(posedge clk) begin
    if (reset) begin
      plot <= 1'b0;
    end else begin
      plot <= sample & on_screen;
    end
  end

  // coordinates only change on a strobe
  always_ff @(posedge clk) begin
    if (sample) begin
      plot_x <= scaled_x;
      plot_y <= scaled_y;
    end
  end

endmodule

`default_nettype wire

//--- adc_xy_scope.sv
`timescale 1ns/100ps
`default_nettype none

module adc_xy_scope #(
  parameter int P_FRAMES = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              sample,
  input  scope_pkg::adc_t   adc_x,
  input  scope_pkg::adc_t   adc_y,
  output scope_pkg::color_t vga_red,
  output scope_pkg::color_t vga_grn,
  output scope_pkg::color_t vga_blu,
  output logic              vga_hsync,
  output logic              vga_vsync
);
  import scope_pkg::*;

  logic  plot;
  fb_x_t plot_x;
  fb_y_t plot_y;
  logic  vblank_start;

  fb_write_if u_fb_wr ();

  // decode samples into screen coordinates
  adc_sample u_adc_sample (
    .clk    (clk),
    .reset  (reset),
    .sample (sample),
    .adc_x  (adc_x),
    .adc_y  (adc_y),
    .plot   (plot),
    .plot_x (plot_x),
    .plot_y (plot_y)
  );

  // plot writes and periodic clear
  fb_plot #(
    .P_FRAMES (P_FRAMES)
  ) u_fb_plot (
    .clk          (clk),
    .reset        (reset),
    .plot         (plot),
    .plot_x       (plot_x),
    .plot_y       (plot_y),
    .vblank_start (vblank_start),
    .wr           (u_fb_wr.writer)
  );

  // framebuffer and raster
  vga_scan u_vga_scan (
    .clk          (clk),
    .reset        (reset),
    .wr           (u_fb_wr.memory),
    .vblank_start (vblank_start),
    .vga_red      (vga_red),
    .vga_grn      (vga_grn),
    .vga_blu      (vga_blu),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync)
  );

endmodule

`default_nettype wire

//--- compile.f
scope_pkg.sv
fb_write_if.sv
adc_sample.sv
fb_plot.sv
vga_scan.sv
adc_xy_scope.sv
scope_sva.sv
scope_checker.sv
tb_adc_xy_scope.sv

//--- fb_plot.sv
`timescale 1ns/100ps
`default_nettype none

module fb_plot #(
  parameter int P_FRAMES = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             plot,
  input  scope_pkg::fb_x_t plot_x,
  input  scope_pkg::fb_y_t plot_y,
  input  logic             vblank_start,
  fb_write_if.writer       wr
);
  import scope_pkg::*;

  // at least one bit, even for a clear on every frame
  localparam int FRAME_BITS = (P_FRAMES > 1) ? $clog2(P_FRAMES) : 1;
  localparam logic [FRAME_BITS-1:0] LAST_FRAME = FRAME_BITS'(P_FRAMES - 1);

  logic [FRAME_BITS-1:0] frame;
  logic                  clearing;
  fb_x_t                 clr_x;
  fb_y_t                 clr_y;
  logic                  clr_last;

  assign clr_last = (clr_x == fb_x_t'(FB_WIDTH - 1)) && (clr_y == fb_y_t'(FB_HEIGHT - 1));

  // persistence counter, starts on the last frame so the first vblank clears
  always_ff @(posedge clk) begin
    if (reset) begin
      frame <= LAST_FRAME;
    end else if (vblank_start) begin
      if (frame == LAST_FRAME) begin
        frame <= '0;
      end else begin
        frame <= frame + 1'b1;
      end
    end
  end

  // clear sweep in row-major order
  always_ff @(posedge clk) begin
    if (reset) begin
      clearing <= 1'b0;
      clr_x <= '0;
      clr_y <= '0;
    end else if (clearing) begin
      if (clr_x == fb_x_t'(FB_WIDTH - 1)) begin
        clr_x <= '0;
        if (clr_last) begin
          clr_y <= '0;
          clearing <= 1'b0;
        end else begin
          clr_y <= clr_y + 1'b1;
        end
      end else begin
        clr_x <= clr_x + 1'b1;
      end
    end else if (vblank_start && frame == LAST_FRAME) begin
      clearing <= 1'b1;
    end
  end

  // plots arriving during a sweep are lost
  always_ff @(posedge clk) begin
    if (reset) begin
      wr.we <= 1'b0;
    end else begin
      wr.we <= clearing | plot;
    end
  end

  always_ff @(posedge clk) begin
    if (clearing) begin
      wr.x <= clr_x;
      wr.y <= clr_y;
      wr.color <= PIXEL_OFF;
    end else begin
      wr.x <= plot_x;
      wr.y <= plot_y;
      wr.color <= PIXEL_ON;
    end
  end

endmodule

`default_nettype wire

//--- fb_write_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fb_write_if;
  import scope_pkg::*;

  // one pixel write per cycle while we is high
  logic we;
  fb_x_t x;
  fb_y_t y;
  pixel_t color;

  modport writer (
    output we, x, y, color
  );

  modport memory (
    input we, x, y, color
  );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_xy_scope -f compile.f
output=$(./obj_dir/Vtb_adc_xy_scope 2>&1) || true
echo "$output"
if echo "$output" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

//--- scope_checker.sv
`timescale 1ns/100ps
`default_nettype none

module scope_checker #(
  parameter int P_FRAMES = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              sample,
  input  scope_pkg::adc_t   adc_x,
  input  scope_pkg::adc_t   adc_y,
  input  scope_pkg::color_t vga_red,
  input  scope_pkg::color_t vga_grn,
  input  scope_pkg::color_t vga_blu,
  input  logic              vga_hsync,
  input  logic              vga_vsync,
  output int                pixel_errors,
  output int                sync_errors
);
  import scope_pkg::*;

  // adc counts per framebuffer cell
  localparam int ADC_STEP = 32;
  // vsync spans whole lines
  localparam int VSYNC_CYCLES = (V_SYNC_END - V_SYNC_START + 1) * H_TOTAL;

  bit     lit [FB_HEIGHT][FB_WIDTH];
  bit     locked;
  int     col;
  int     line;
  int     frame;
  int     hsync_low;
  int     vsync_low;
  int     frame_cycles;
  logic   hsync_d;
  logic   vsync_d;
  color_t expected;

  task automatic clear_model();
    for (int r = 0; r < FB_HEIGHT; r++) begin
      for (int c = 0; c < FB_WIDTH; c++) begin
        lit[r][c] = 1'b0;
      end
    end
  endtask

  task automatic compare_channel(input string name, input color_t exp_val, input color_t act_val);
    if (act_val !== exp_val) begin
      pixel_errors++;
      $display("error %s expected 0x%h actual 0x%h at line %0d column %0d",
               name, exp_val, act_val, line, col);
    end
  endtask

  task automatic report_sync(input string name, input int exp_val, input int act_val);
    sync_errors++;
    $display("error %s expected 0x%h actual 0x%h", name, exp_val, act_val);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      locked = 1'b0;
      col = 0;
      line = 0;
      frame = 0;
      hsync_low = 0;
      vsync_low = 0;
      frame_cycles = 0;
      hsync_d = 1'b1;
      vsync_d = 1'b1;
      pixel_errors = 0;
      sync_errors = 0;
    end else begin
      // raster position of the pixel now on the outputs
      col = col + 1;
      if (col == H_TOTAL) begin
        col = 0;
        line = (line + 1) % V_TOTAL;
      end
      frame_cycles++;

      if (!vga_hsync) begin
        hsync_low++;
      end else if (!hsync_d) begin
        if (hsync_low != H_SYNC_END - H_SYNC_START + 1) begin
          report_sync("vga_hsync low cycles", H_SYNC_END - H_SYNC_START + 1, hsync_low);
        end
        if (locked && col != H_SYNC_END + 1) begin
          report_sync("vga_hsync rise column", H_SYNC_END + 1, col);
        end
        hsync_low = 0;
      end

      if (!vga_vsync) begin
        vsync_low++;
      end

      // vsync goes high again at column 0 of line 28
      if (vga_vsync && !vsync_d) begin
        if (vsync_low != VSYNC_CYCLES) begin
          report_sync("vga_vsync low cycles", VSYNC_CYCLES, vsync_low);
        end
        vsync_low = 0;
        if (locked && frame_cycles != H_TOTAL * V_TOTAL) begin
          report_sync("vga_vsync period", H_TOTAL * V_TOTAL, frame_cycles);
        end
        if (!locked) begin
          // first vblank after reset has just wrapped the counter and cleared
          locked = 1'b1;
          line = V_SYNC_END + 1;
          col = 0;
          frame = 0;
          clear_model();
        end
        frame_cycles = 0;
      end
      hsync_d = vga_hsync;
      vsync_d = vga_vsync;

      // persistence counter steps on the first blank line
      if (locked && col == 0 && line == FB_HEIGHT) begin
        frame = (frame + 1) % P_FRAMES;
        if (frame == 0) begin
          clear_model();
        end
      end

      if (sample && int'(adc_y) / ADC_STEP < FB_HEIGHT) begin
        lit[int'(adc_y) / ADC_STEP][int'(adc_x) / ADC_STEP] = 1'b1;
      end

      if (locked) begin
        expected = 4'h0;
        if (line < FB_HEIGHT && col < FB_WIDTH && lit[line][col]) begin
          expected = 4'hf;
        end
        compare_channel("vga_red", expected, vga_red);
        compare_channel("vga_grn", expected, vga_grn);
        compare_channel("vga_blu", expected, vga_blu);
      end
    end
  end

endmodule

`default_nettype wire

//--- scope_pkg.sv
`default_nettype none

package scope_pkg;

  // one ADC reading
  typedef logic [9:0] adc_t;

  // framebuffer coordinates
  typedef logic [4:0] fb_x_t;
  typedef logic [4:0] fb_y_t;

  // packed color, red in the top nibble
  typedef logic [11:0] pixel_t;
  typedef logic [3:0] color_t;

  localparam int FB_WIDTH = 32;
  localparam int FB_HEIGHT = 24;

  // miniature raster, one clock per pixel
  localparam int H_TOTAL = 40;
  localparam int H_SYNC_START = 34;
  localparam int H_SYNC_END = 37;
  localparam int V_TOTAL = 48;
  localparam int V_SYNC_START = 26;
  localparam int V_SYNC_END = 27;

  localparam pixel_t PIXEL_ON = '1;
  localparam pixel_t PIXEL_OFF = '0;

endpackage

`default_nettype wire

//--- scope_sva.sv
`timescale 1ns/100ps
`default_nettype none

module scope_sva (
  input logic              clk,
  input logic              reset,
  input logic              we,
  input scope_pkg::fb_x_t  wr_x,
  input scope_pkg::fb_y_t  wr_y,
  input logic              vblank_start,
  input scope_pkg::color_t vga_red,
  input scope_pkg::color_t vga_grn,
  input scope_pkg::color_t vga_blu,
  input logic              vga_hsync,
  input logic              vga_vsync
);
  import scope_pkg::*;

  int   hsync_low;
  int   since_vblank;
  logic vblank_seen;

  always_ff @(posedge clk) begin
    if (reset) begin
      hsync_low <= 0;
    end else if (!vga_hsync) begin
      hsync_low <= hsync_low + 1;
    end else begin
      hsync_low <= 0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      since_vblank <= 0;
      vblank_seen <= 1'b0;
    end else if (vblank_start) begin
      since_vblank <= 1;
      vblank_seen <= 1'b1;
    end else begin
      since_vblank <= since_vblank + 1;
    end
  end

  // four clocks of hsync
  assert property (@(posedge clk) disable iff (reset)
    $rose(vga_hsync) |-> hsync_low == H_SYNC_END - H_SYNC_START + 1)
    else $error("vga_hsync was low for %0d cycles", hsync_low);

  assert property (@(posedge clk) disable iff (reset)
    vblank_seen |-> (vblank_start == (since_vblank == H_TOTAL * V_TOTAL)))
    else $error("vblank_start out of step, %0d cycles since the last one", since_vblank);

  // black during sync
  assert property (@(posedge clk) disable iff (reset)
    (!vga_hsync || !vga_vsync) |-> (vga_red == '0 && vga_grn == '0 && vga_blu == '0))
    else $error("colors not black while a sync is active");

  assert property (@(posedge clk) disable iff (reset)
    we |-> (int'(wr_y) < FB_HEIGHT))
    else $error("framebuffer write outside the screen at x %0d y %0d", wr_x, wr_y);

endmodule

bind vga_scan scope_sva u_scope_sva (
  .clk          (clk),
  .reset        (reset),
  .we           (wr.we),
  .wr_x         (wr.x),
  .wr_y         (wr.y),
  .vblank_start (vblank_start),
  .vga_red      (vga_red),
  .vga_grn      (vga_grn),
  .vga_blu      (vga_blu),
  .vga_hsync    (vga_hsync),
  .vga_vsync    (vga_vsync)
);

`default_nettype wire

//--- scope_testdata.txt
// frame adc_x adc_y, all hex, one sample per line
// frame fff ends the list
000 000 000
000 3ff 2ff
000 155 300
001 0a0 140
001 210 3ff
002 2c0 0e0
003 1e0 1e0
004 3e0 000
004 100 220
005 0ff 3a5
006 080 080
007 300 1c0
009 11f 0bf
fff 000 000

//--- tb_adc_xy_scope.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adc_xy_scope;
  import scope_pkg::*;

  localparam int P_FRAMES = 4;
  localparam int MAX_RECORDS = 16;
  localparam logic [11:0] END_FRAME = 12'hfff;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

  logic   clk;
  logic   reset;
  logic   sample;
  adc_t   adc_x;
  adc_t   adc_y;
  color_t vga_red;
  color_t vga_grn;
  color_t vga_blu;
  logic   vga_hsync;
  logic   vga_vsync;

  int pixel_errors;
  int sync_errors;
  int timeouts;
  int setup_errors;
  int records;
  int rec;
  int last_frame;

  // three words per record: frame, adc x, adc y
  logic [11:0] stim [3 * MAX_RECORDS];

  always #20 clk = ~clk;

  adc_xy_scope #(
    .P_FRAMES (P_FRAMES)
  ) u_adc_xy_scope (
    .clk       (clk),
    .reset     (reset),
    .sample    (sample),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  scope_checker #(
    .P_FRAMES (P_FRAMES)
  ) u_checker (
    .clk          (clk),
    .reset        (reset),
    .sample       (sample),
    .adc_x        (adc_x),
    .adc_y        (adc_y),
    .vga_red      (vga_red),
    .vga_grn      (vga_grn),
    .vga_blu      (vga_blu),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync),
    .pixel_errors (pixel_errors),
    .sync_errors  (sync_errors)
  );

  // count rising edges of one sync, giving up after limit clocks
  task automatic wait_sync_rises(input bit vertical, input int count, input int limit);
    int   seen;
    int   cycles;
    logic now;
    logic last;
    seen = 0;
    cycles = 0;
    last = vertical ? vga_vsync : vga_hsync;
    while (seen < count && cycles < limit) begin
      @(posedge clk);
      now = vertical ? vga_vsync : vga_hsync;
      if (now && !last) begin
        seen++;
      end
      last = now;
      cycles++;
    end
    if (seen < count) begin
      timeouts++;
      $display("timeout: saw only %0d of %0d rising edges of %s in %0d cycles",
               seen, count, vertical ? "vga_vsync" : "vga_hsync", limit);
    end
  endtask

  // one strobe, then three idle clocks
  task automatic drive_sample(input adc_t x, input adc_t y);
    @(posedge clk);
    sample <= 1'b1;
    adc_x <= x;
    adc_y <= y;
    @(posedge clk);
    sample <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    sample = 1'b0;
    adc_x = '0;
    adc_y = '0;
    timeouts = 0;
    setup_errors = 0;
    rec = 0;
    $readmemh("scope_testdata.txt", stim);
    records = 0;
    while (records < MAX_RECORDS && stim[3 * records] !== END_FRAME) begin
      records++;
    end
    last_frame = -1;
    if (records == MAX_RECORDS || records == 0) begin
      setup_errors++;
      $display("stimulus file scope_testdata.txt is missing, empty or has no end marker");
    end else begin
      last_frame = int'(stim[3 * (records - 1)]);
    end

    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // samples go in at line 44, after the clear sweep has finished
    for (int f = 0; f <= last_frame; f++) begin
      wait_sync_rises(1'b1, 1, 2 * FRAME_CYCLES);
      wait_sync_rises(1'b0, 16, 17 * H_TOTAL);
      while (rec < records && int'(stim[3 * rec]) == f) begin
        drive_sample(adc_t'(stim[3 * rec + 1]), adc_t'(stim[3 * rec + 2]));
        rec++;
      end
    end
    // let the last samples reach the screen
    wait_sync_rises(1'b1, 2, 3 * FRAME_CYCLES);

    $display("errors: pixel %0d, sync %0d, timeout %0d, setup %0d",
             pixel_errors, sync_errors, timeouts, setup_errors);
    if (pixel_errors + sync_errors + timeouts + setup_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vga_scan.sv
`timescale 1ns/100ps
`default_nettype none

module vga_scan (
  input  logic              clk,
  input  logic              reset,
  fb_write_if.memory        wr,
  output logic              vblank_start,
  output scope_pkg::color_t vga_red,
  output scope_pkg::color_t vga_grn,
  output scope_pkg::color_t vga_blu,
  output logic              vga_hsync,
  output logic              vga_vsync
);
  import scope_pkg::*;

  localparam int FB_WORDS = FB_WIDTH * FB_HEIGHT;
  localparam int H_BITS = $clog2(H_TOTAL);
  localparam int V_BITS = $clog2(V_TOTAL);
  localparam int ADDR_BITS = $bits(fb_y_t) + $bits(fb_x_t);

  pixel_t mem [FB_WORDS];

  logic [H_BITS-1:0]    h_count;
  logic [V_BITS-1:0]    v_count;
  logic                 line_end;
  logic                 visible;
  logic                 hsync_on;
  logic                 vsync_on;
  logic [ADDR_BITS-1:0] wr_addr;
  logic [ADDR_BITS-1:0] rd_addr;
  pixel_t               pixel_q;
  logic                 visible_q;

  // row-major address, a row is exactly 32 words wide
  assign wr_addr = {wr.y, wr.x};
  assign rd_addr = {fb_y_t'(v_count), fb_x_t'(h_count)};

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr_addr] <= wr.color;
    end
  end

  // raster counters
  assign line_end = (h_count == H_BITS'(H_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      if (v_count == V_BITS'(V_TOTAL - 1)) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign visible = (h_count < FB_WIDTH) && (v_count < FB_HEIGHT);
  assign hsync_on = (h_count >= H_SYNC_START) && (h_count <= H_SYNC_END);
  assign vsync_on = (v_count >= V_SYNC_START) && (v_count <= V_SYNC_END);

  // first clock of the first blank line
  assign vblank_start = (v_count == V_BITS'(FB_HEIGHT)) && (h_count == '0);

  // registered read, only inside the visible area
  always_ff @(posedge clk) begin
    if (visible) begin
      pixel_q <= mem[rd_addr];
    end
  end

  // syncs take the same one-cycle delay as the read
  always_ff @(posedge clk) begin
    if (reset) begin
      visible_q <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      visible_q <= visible;
      vga_hsync <= ~hsync_on;
      vga_vsync <= ~vsync_on;
    end
  end

  // black outside the visible area
  assign vga_red = visible_q ? pixel_q[11:8] : '0;
  assign vga_grn = visible_q ? pixel_q[7:4] : '0;
  assign vga_blu = visible_q ? pixel_q[3:0] : '0;

endmodule

`default_nettype wire
